//--- tests/alu_vectors.txt
# I op dest r1_rdy r1_tag r1_val r2_rdy r2_tag r2_val | E tag value exc_flag exc_code | C tag value
# F flush | S stall_percent | Q idle_cycles | D drain | R issue_ready; hex except S and Q
# All operations with ready operands under random back-pressure
S 50
E 1 0000000000000001 0 0
I 0 1 1 0 ffffffffffffffff 1 0 0000000000000002
E 2 fffffffffffffff0 0 0
I 1 2 1 0 0000000000000010 1 0 0000000000000020
E 3 f000f000f000f000 0 0
I 2 3 1 0 f0f0f0f0f0f0f0f0 1 0 ff00ff00ff00ff00
E 4 fff0f0f0f0f0f0ff 0 0
I 3 4 1 0 f0f0f0f0f0f0f0f0 1 0 0f0000000000000f
E 5 55555555aaaaaaaa 0 0
I 4 5 1 0 aaaaaaaaaaaaaaaa 1 0 ffffffff00000000
E 6 8000000000000000 0 0
I 5 6 1 0 0000000000000001 1 0 000000000000007f
E 7 0800000000000000 0 0
I 6 7 1 0 8000000000000000 1 0 0000000000000044
E 8 fffffffffffffff8 0 0
I 7 8 1 0 8000000000000000 1 0 000000000000003c
E 9 0000000000000001 0 0
I 8 9 1 0 ffffffffffffffff 1 0 0000000000000001
E a 0000000000000000 0 0
I 9 a 1 0 ffffffffffffffff 1 0 0000000000000001
E b ffffffff80000000 0 0
I a b 1 0 123456787fffffff 1 0 0000000000000001
E c ffffffffffffffff 0 0
I b c 1 0 1234567800000000 1 0 0000000000000001
E d ffffffff80000000 0 0
I c d 1 0 ffffffff00000001 1 0 000000000000003f
E e 0000000008000000 0 0
I d e 1 0 ffffffff80000000 1 0 0000000000000024
E f ffffffffffffffff 0 0
I e f 1 0 0000000080000000 1 0 000000000000003f
# Unused opcode 15
E 0 0000000000000000 1 2
I f 0 1 0 0000000000000005 1 0 0000000000000006
D
# Operands waiting on producer tags 5 and 6
S 0
I 0 1 0 5 0 0 6 0
I b 2 1 0 0000000000000010 0 6 0
Q 10
C 5 0000000000000100
Q 10
E 1 0000000000000123 0 0
E 2 ffffffffffffffed 0 0
C 6 0000000000000023
D
# Four entries waiting on tag 9 fill the station
I 0 2 0 9 0 1 0 0000000000000001
I 2 3 0 9 0 1 0 00000000000000ff
I 3 4 0 9 0 1 0 0000000000000100
I 4 5 0 9 0 1 0 000000000000ffff
R 0
S 30
E 2 00000000000000f1 0 0
E 3 00000000000000f0 0 0
E 4 00000000000001f0 0 0
E 5 000000000000ff0f 0 0
C 9 00000000000000f0
D
R 1
# Flush with two results held in the spill cell and one entry waiting
S 100
I 0 6 1 0 0000000000000001 1 0 0000000000000002
I 0 7 1 0 0000000000000003 1 0 0000000000000004
I 1 8 0 a 0 1 0 0000000000000001
Q 5
F
S 0
C a 0000000000000050
Q 20
E 9 0000000000000030 0 0
I 0 9 1 0 0000000000000010 1 0 0000000000000020
D

//--- project.f
+incdir+include
source/isa_pkg.sv
source/expipe_pkg.sv
source/spill_cell_flush.sv
source/alu_rs.sv
source/alu.sv
source/alu_unit.sv
tests/tb_alu_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ALU unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_alu_unit
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tests/tb_alu_unit.sv
// --------------------------------------
// ALU execution unit testbench
// Replays issue, CDB and flush records
// from a vector file, matches results by
// tag and watches the result handshake
// --------------------------------------

`timescale 1ns/1ps

module tb_alu_unit;

    import isa_pkg::*;
    import expipe_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk_i;
    logic       rst_i;
    logic       flush_i;
    logic       issue_valid_i;
    logic       issue_ready_o;
    alu_issue_t issue_i;
    logic       cdb_valid_i;
    cdb_pkt_t   cdb_i;
    logic       res_valid_o;
    logic       res_ready_i;
    cdb_pkt_t   res_o;

    // Results still owed by the DUT
    cdb_pkt_t   exp_q[$];
    // Chance in percent of a low res_ready_i
    int         stall_pct;

    // Snapshot of a stalled result
    logic       hold_q = 1'b0;
    cdb_pkt_t   hold_pkt;

    alu_unit alu_unit_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_i         (cdb_i),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i),
        .res_o         (res_o)
    );

    // 4 ns period
    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------
    // Checks
    // --------------------------------------

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_data(input string name, input xlen_t exp_v, input xlen_t act_v);
        if (act_v !== exp_v) begin
            stop_with_error($sformatf("[FAIL] %s expected 0x%h actual 0x%h",
                                      name, exp_v, act_v));
        end
    endtask

    task automatic compare_except(input string name, input logic exp_flag,
                                  input except_code_t exp_code, input logic act_flag,
                                  input except_code_t act_code);
        if ((act_flag !== exp_flag) || (act_code !== exp_code)) begin
            stop_with_error($sformatf({"[FAIL] %s expected flag 0x%h code 0x%h",
                                       " actual flag 0x%h code 0x%h"},
                                      name, exp_flag, exp_code, act_flag, act_code));
        end
    endtask

    task automatic compare_tag(input string name, input rob_tag_t exp_v, input rob_tag_t act_v);
        if (act_v !== exp_v) begin
            stop_with_error($sformatf("[FAIL] %s expected 0x%h actual 0x%h",
                                      name, exp_v, act_v));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            stop_with_error($sformatf("[FAIL] %s expected 0x%h actual 0x%h",
                                      name, exp_v, act_v));
        end
    endtask

    // --------------------------------------
    // Drivers
    // --------------------------------------

    // Inputs change half a ns after the edge
    task automatic next_drive();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic issue_instr(input alu_issue_t instr);
        int waited;
        waited        = 0;
        issue_i       = instr;
        issue_valid_i = 1'b1;
        // Ready sampled mid-cycle, transfer on the next edge
        @(negedge clk_i);
        while (!issue_ready_o) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("Timed out waiting for issue_ready_o, tag %h",
                                          instr.dest_tag));
            end
            @(negedge clk_i);
        end
        next_drive();
        issue_valid_i = 1'b0;
    endtask

    // One-cycle broadcast from another unit
    task automatic broadcast(input rob_tag_t tag, input xlen_t value);
        cdb_i       = '0;
        cdb_i.tag   = tag;
        cdb_i.value = value;
        cdb_valid_i = 1'b1;
        next_drive();
        cdb_valid_i = 1'b0;
    endtask

    task automatic pulse_flush();
        flush_i = 1'b1;
        next_drive();
        flush_i = 1'b0;
    endtask

    // Wait until every expected result was seen
    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("Timed out with %0d results still missing",
                                          exp_q.size()));
            end
            next_drive();
            waited++;
        end
    endtask

    // Random back-pressure, percentage read at the edge
    initial begin : ready_driver
        logic stall;
        // Fixed seed for the stall pattern
        void'($urandom(27600));
        res_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            stall = int'($urandom % 100) < stall_pct;
            #0.5;
            res_ready_i = !stall;
        end
    end

    // --------------------------------------
    // Result monitor
    // --------------------------------------

    // Sampled at the falling edge, outputs settled
    always @(negedge clk_i) begin : result_monitor
        int idx;
        idx = -1;
        // Stalled result must stay put
        if (hold_q) begin
            if (!res_valid_o) begin
                stop_with_error("res_valid_o dropped while res_ready_i was low");
            end else begin
                compare_tag("res_o.tag", hold_pkt.tag, res_o.tag);
                compare_data("res_o.value", hold_pkt.value, res_o.value);
                compare_except("res_o.except", hold_pkt.except_raised, hold_pkt.except_code,
                               res_o.except_raised, res_o.except_code);
            end
        end
        if (res_valid_o && res_ready_i && !rst_i) begin
            for (int i = 0; i < exp_q.size(); i++) begin
                if ((idx < 0) && (exp_q[i].tag == res_o.tag)) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                stop_with_error($sformatf("Result with unexpected tag %h appeared", res_o.tag));
            end else begin
                compare_data("res_o.value", exp_q[idx].value, res_o.value);
                compare_except("res_o.except", exp_q[idx].except_raised,
                               exp_q[idx].except_code, res_o.except_raised,
                               res_o.except_code);
                exp_q.delete(idx);
            end
        end
        // Flush may legally drop a held result
        hold_q   = res_valid_o && !res_ready_i && !flush_i && !rst_i;
        hold_pkt = res_o;
    end

    // --------------------------------------
    // Vector replay
    // --------------------------------------

    task automatic run_vectors(input int fd);
        int          n;
        string       cmd;
        string       line;
        logic [63:0] f [8];
        alu_issue_t  instr;
        cdb_pkt_t    pkt;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                void'($fgets(line, fd));
            end else if (cmd == "I") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 8) begin
                    stop_with_error("Malformed issue record in the vector file");
                end else begin
                    instr.op        = alu_op_t'(f[0][3:0]);
                    instr.dest_tag  = rob_tag_t'(f[1]);
                    instr.rs1.ready = f[2][0];
                    instr.rs1.tag   = rob_tag_t'(f[3]);
                    instr.rs1.value = f[4];
                    instr.rs2.ready = f[5][0];
                    instr.rs2.tag   = rob_tag_t'(f[6]);
                    instr.rs2.value = f[7];
                    issue_instr(instr);
                end
            end else if (cmd == "E") begin
                n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                if (n != 4) begin
                    stop_with_error("Malformed expected-result record in the vector file");
                end else begin
                    pkt.tag           = rob_tag_t'(f[0]);
                    pkt.value         = f[1];
                    pkt.except_raised = f[2][0];
                    pkt.except_code   = except_code_t'(f[3]);
                    exp_q.push_back(pkt);
                end
            end else if (cmd == "C") begin
                n = $fscanf(fd, "%h %h", f[0], f[1]);
                if (n != 2) begin
                    stop_with_error("Malformed broadcast record in the vector file");
                end else begin
                    broadcast(rob_tag_t'(f[0]), f[1]);
                end
            end else if (cmd == "S") begin
                n = $fscanf(fd, "%d", stall_pct);
                if (n != 1) begin
                    stop_with_error("Malformed stall record in the vector file");
                end
            end else if (cmd == "Q") begin
                n = $fscanf(fd, "%d", f[0]);
                if (n != 1) begin
                    stop_with_error("Malformed idle record in the vector file");
                end else begin
                    repeat (int'(f[0])) next_drive();
                end
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%h", f[0]);
                if (n != 1) begin
                    stop_with_error("Malformed issue-ready record in the vector file");
                end else begin
                    @(negedge clk_i);
                    compare_bit("issue_ready_o", f[0][0], issue_ready_o);
                    next_drive();
                end
            end else if (cmd == "F") begin
                pulse_flush();
            end else if (cmd == "D") begin
                drain_results();
            end else begin
                stop_with_error($sformatf("Unknown record %s in the vector file", cmd));
            end
        end
    endtask

    initial begin : stimulus
        int fd;
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cdb_valid_i   = 1'b0;
        cdb_i         = '0;
        stall_pct     = 0;
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_i = 1'b0;
        // Idle state right after reset
        compare_bit("issue_ready_o", 1'b1, issue_ready_o);
        compare_bit("res_valid_o", 1'b0, res_valid_o);
        fd = $fopen("tests/alu_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open tests/alu_vectors.txt");
        end else begin
            run_vectors(fd);
            $fclose(fd);
        end
        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d expected results never appeared", exp_q.size()));
        end
    end

endmodule

//--- source/alu_unit.sv
// --------------------------------------
// ALU execution unit
// Reservation station in front of the
// ALU, results leave as CDB requests
// --------------------------------------

`timescale 1ns/1ps

module alu_unit (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,

    // Issue stage
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  expipe_pkg::alu_issue_t issue_i,

    // CDB snoop
    input  logic                   cdb_valid_i,
    input  expipe_pkg::cdb_pkt_t   cdb_i,

    // Result request to the CDB
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output expipe_pkg::cdb_pkt_t   res_o
);

    import expipe_pkg::*;

    // Station to ALU dispatch channel
    logic     disp_valid;
    logic     disp_ready;
    alu_req_t disp;

    // --------------------------------------
    // Reservation station
    // --------------------------------------

    alu_rs u_alu_rs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_i         (cdb_i),
        .disp_valid_o  (disp_valid),
        .disp_ready_i  (disp_ready),
        .disp_o        (disp)
    );

    // --------------------------------------
    // ALU and output buffer
    // --------------------------------------

    alu u_alu (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .valid_i (disp_valid),
        .ready_o (disp_ready),
        .req_i   (disp),
        .valid_o (res_valid_o),
        .ready_i (res_ready_i),
        .res_o   (res_o)
    );

endmodule

//--- source/alu.sv
// --------------------------------------
// RV64 integer ALU
// Combinational datapath for base and W
// operations, result buffered in a spill
// cell as a CDB write request
// --------------------------------------

`timescale 1ns/1ps

`include "len5_params.svh"

module alu (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flush_i,

    // From the reservation station
    input  logic                 valid_i,
    output logic                 ready_o,
    input  expipe_pkg::alu_req_t req_i,

    // To the CDB
    output logic                 valid_o,
    input  logic                 ready_i,
    output expipe_pkg::cdb_pkt_t res_o
);

    import isa_pkg::*;
    import expipe_pkg::*;

    xlen_t       result;
    logic [31:0] word_res;
    logic        is_word;
    logic        except_raised;
    cdb_pkt_t    alu_pkt;

    // --------------------------------------
    // Operations
    // --------------------------------------

    always_comb begin : alu_ops
        result        = '0;
        word_res      = '0;
        is_word       = 1'b0;
        except_raised = 1'b0;
        case (req_i.op)
            ALU_ADD:  result = req_i.rs1_value + req_i.rs2_value;
            ALU_SUB:  result = req_i.rs1_value - req_i.rs2_value;
            ALU_AND:  result = req_i.rs1_value & req_i.rs2_value;
            ALU_OR:   result = req_i.rs1_value | req_i.rs2_value;
            ALU_XOR:  result = req_i.rs1_value ^ req_i.rs2_value;
            // Shift amount from the low 6 bits
            ALU_SLL:  result = req_i.rs1_value << req_i.rs2_value[5:0];
            ALU_SRL:  result = req_i.rs1_value >> req_i.rs2_value[5:0];
            ALU_SRA:  result = $signed(req_i.rs1_value) >>> req_i.rs2_value[5:0];
            ALU_SLT:  result = xlen_t'($signed(req_i.rs1_value) < $signed(req_i.rs2_value));
            ALU_SLTU: result = xlen_t'(req_i.rs1_value < req_i.rs2_value);
            // W forms on the low word, 5-bit shifts
            ALU_ADDW: begin
                is_word  = 1'b1;
                word_res = req_i.rs1_value[31:0] + req_i.rs2_value[31:0];
            end
            ALU_SUBW: begin
                is_word  = 1'b1;
                word_res = req_i.rs1_value[31:0] - req_i.rs2_value[31:0];
            end
            ALU_SLLW: begin
                is_word  = 1'b1;
                word_res = req_i.rs1_value[31:0] << req_i.rs2_value[4:0];
            end
            ALU_SRLW: begin
                is_word  = 1'b1;
                word_res = req_i.rs1_value[31:0] >> req_i.rs2_value[4:0];
            end
            ALU_SRAW: begin
                is_word  = 1'b1;
                word_res = $signed(req_i.rs1_value[31:0]) >>> req_i.rs2_value[4:0];
            end
            // Unknown opcode, zero result
            default:  except_raised = 1'b1;
        endcase
        // Sign-extend bit 31 for the W forms
        if (is_word) begin
            result = {{(`LEN5_XLEN-32){word_res[31]}}, word_res};
        end
    end

    // CDB packet, tag passes straight through
    assign alu_pkt.tag           = req_i.dest_tag;
    assign alu_pkt.value         = result;
    assign alu_pkt.except_raised = except_raised;
    assign alu_pkt.except_code   = except_raised ? E_ILLEGAL_INSTRUCTION : '0;

    // --------------------------------------
    // Output buffer
    // --------------------------------------

    spill_cell_flush #(
        .DATA_T (cdb_pkt_t)
    ) u_out_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_i (ready_i),
        .valid_o (valid_o),
        .ready_o (ready_o),
        .data_i  (alu_pkt),
        .data_o  (res_o)
    );

endmodule

//--- source/alu_rs.sv
// --------------------------------------
// ALU reservation station
// Holds issued instructions, snoops the
// CDB for missing operands and sends the
// oldest-slot ready entry to the ALU
// --------------------------------------

`timescale 1ns/1ps

`include "len5_params.svh"

module alu_rs (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,

    // Issue stage
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  expipe_pkg::alu_issue_t issue_i,

    // CDB snoop
    input  logic                   cdb_valid_i,
    input  expipe_pkg::cdb_pkt_t   cdb_i,

    // Dispatch to the ALU
    output logic                   disp_valid_o,
    input  logic                   disp_ready_i,
    output expipe_pkg::alu_req_t   disp_o
);

    import expipe_pkg::*;

    localparam int unsigned DEPTH = `LEN5_RS_DEPTH;

    // Station storage
    rs_state_t  state_q [DEPTH];
    alu_issue_t entry_q [DEPTH];

    // Operands after this cycle's CDB match
    operand_t   rs1_snoop [DEPTH];
    operand_t   rs2_snoop [DEPTH];
    alu_issue_t alloc_entry;

    logic       free_found;
    logic       ready_found;
    rs_idx_t    free_idx;
    rs_idx_t    disp_idx;
    logic       issue_fire;
    logic       disp_fire;

    // Capture the bus value on a tag hit
    function automatic operand_t snoop_operand(
        input operand_t op_in,
        input logic     bus_valid,
        input cdb_pkt_t bus
    );
        operand_t op_out;
        op_out = op_in;
        if (bus_valid && !op_in.ready && (op_in.tag == bus.tag)) begin
            op_out.ready = 1'b1;
            op_out.value = bus.value;
        end
        return op_out;
    endfunction

    // --------------------------------------
    // Wakeup
    // --------------------------------------

    always_comb begin : wakeup
        for (int i = 0; i < DEPTH; i++) begin
            rs1_snoop[i] = snoop_operand(entry_q[i].rs1, cdb_valid_i, cdb_i);
            rs2_snoop[i] = snoop_operand(entry_q[i].rs2, cdb_valid_i, cdb_i);
        end
    end

    // Incoming instruction may hit the bus in its issue cycle
    always_comb begin : alloc_snoop
        alloc_entry     = issue_i;
        alloc_entry.rs1 = snoop_operand(issue_i.rs1, cdb_valid_i, cdb_i);
        alloc_entry.rs2 = snoop_operand(issue_i.rs2, cdb_valid_i, cdb_i);
    end

    // --------------------------------------
    // Priority encoders
    // --------------------------------------

    // Downward scan, lowest index wins
    always_comb begin : select_enc
        free_found  = 1'b0;
        ready_found = 1'b0;
        free_idx    = '0;
        disp_idx    = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == EMPTY) begin
                free_found = 1'b1;
                free_idx   = rs_idx_t'(i);
            end
            if (state_q[i] == READY) begin
                ready_found = 1'b1;
                disp_idx    = rs_idx_t'(i);
            end
        end
    end

    assign issue_ready_o = free_found;
    assign issue_fire    = issue_valid_i & issue_ready_o;
    assign disp_valid_o  = ready_found;
    assign disp_fire     = disp_valid_o & disp_ready_i;

    // Operands of a READY entry are always resolved
    assign disp_o.op        = entry_q[disp_idx].op;
    assign disp_o.dest_tag  = entry_q[disp_idx].dest_tag;
    assign disp_o.rs1_value = entry_q[disp_idx].rs1.value;
    assign disp_o.rs2_value = entry_q[disp_idx].rs2.value;

    // --------------------------------------
    // Entry state
    // --------------------------------------

    always_ff @(posedge clk_i) begin : state_regs
        if (rst_i || flush_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= EMPTY;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                case (state_q[i])
                    EMPTY: begin
                        if (issue_fire && (free_idx == rs_idx_t'(i))) begin
                            state_q[i] <= (alloc_entry.rs1.ready && alloc_entry.rs2.ready)
                                          ? READY : WAITING;
                        end
                    end
                    WAITING: begin
                        if (rs1_snoop[i].ready && rs2_snoop[i].ready) begin
                            state_q[i] <= READY;
                        end
                    end
                    READY: begin
                        // Freed at the dispatch transfer
                        if (disp_fire && (disp_idx == rs_idx_t'(i))) begin
                            state_q[i] <= EMPTY;
                        end
                    end
                    default: state_q[i] <= EMPTY;
                endcase
            end
        end
    end

    // Payload, snooped operands written back every cycle
    always_ff @(posedge clk_i) begin : entry_regs
        for (int i = 0; i < DEPTH; i++) begin
            if (issue_fire && (free_idx == rs_idx_t'(i))) begin
                entry_q[i] <= alloc_entry;
            end else begin
                entry_q[i].rs1 <= rs1_snoop[i];
                entry_q[i].rs2 <= rs2_snoop[i];
            end
        end
    end

endmodule

//--- source/spill_cell_flush.sv
// --------------------------------------
// Spill cell with flush
// Two-slot skid register on a valid/ready
// channel, ready_o comes from a flop
// --------------------------------------

`timescale 1ns/1ps

module spill_cell_flush #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  flush_i,
    input  logic  valid_i,
    input  logic  ready_i,
    output logic  valid_o,
    output logic  ready_o,
    input  DATA_T data_i,
    output DATA_T data_o
);

    // Main slot feeds the output, spill slot catches the overflow
    DATA_T main_q;
    DATA_T spill_q;
    logic  main_valid_q;
    logic  spill_valid_q;

    logic  in_fire;
    logic  out_fire;

    // Upstream stalls only once the spill slot is taken
    assign ready_o  = ~spill_valid_q;
    assign valid_o  = main_valid_q;
    assign data_o   = main_q;

    assign in_fire  = valid_i & ready_o;
    assign out_fire = main_valid_q & ready_i;

    // --------------------------------------
    // Slot occupancy
    // --------------------------------------

    // Spill valid implies main valid
    always_ff @(posedge clk_i) begin : ctrl_regs
        if (rst_i || flush_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (spill_valid_q) begin
            // Spill moves down, main stays full
            if (out_fire) begin
                spill_valid_q <= 1'b0;
            end
        end else if (in_fire) begin
            if (main_valid_q && !out_fire) begin
                spill_valid_q <= 1'b1;
            end else begin
                main_valid_q <= 1'b1;
            end
        end else if (out_fire) begin
            main_valid_q <= 1'b0;
        end
    end

    // --------------------------------------
    // Payload
    // --------------------------------------

    always_ff @(posedge clk_i) begin : data_regs
        if (spill_valid_q) begin
            if (out_fire) begin
                main_q <= spill_q;
            end
        end else if (in_fire) begin
            // Main busy and held, park the new item
            if (main_valid_q && !out_fire) begin
                spill_q <= data_i;
            end else begin
                main_q <= data_i;
            end
        end
    end

endmodule

//--- source/expipe_pkg.sv
// --------------------------------------
// Execution pipeline types
// ALU opcodes, tagged operands, issue and
// dispatch packets, CDB packets and the
// reservation station entry state
// --------------------------------------

`include "len5_params.svh"

package expipe_pkg;

    import isa_pkg::*;

    // ROB tag and station index
    typedef logic [`LEN5_ROB_TAG_LEN-1:0] rob_tag_t;
    typedef logic [$clog2(`LEN5_RS_DEPTH)-1:0] rs_idx_t;

    // --------------------------------------
    // ALU opcodes
    // --------------------------------------

    // Code 15 unused, decoded as illegal
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_ADDW = 4'd10,
        ALU_SUBW = 4'd11,
        ALU_SLLW = 4'd12,
        ALU_SRLW = 4'd13,
        ALU_SRAW = 4'd14
    } alu_op_t;

    // --------------------------------------
    // Packets
    // --------------------------------------

    // Value when ready, else producer tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        xlen_t    value;
    } operand_t;

    // From the issue stage
    typedef struct packed {
        alu_op_t  op;
        rob_tag_t dest_tag;
        operand_t rs1;
        operand_t rs2;
    } alu_issue_t;

    // To the ALU, operands resolved
    typedef struct packed {
        alu_op_t  op;
        rob_tag_t dest_tag;
        xlen_t    rs1_value;
        xlen_t    rs2_value;
    } alu_req_t;

    // Common data bus write
    typedef struct packed {
        rob_tag_t     tag;
        xlen_t        value;
        logic         except_raised;
        except_code_t except_code;
    } cdb_pkt_t;

    // Per-entry state of the reservation station
    typedef enum logic [1:0] {
        EMPTY,
        WAITING,
        READY
    } rs_state_t;

endpackage

//--- source/isa_pkg.sv
// --------------------------------------
// ISA-level types
// Data words and exception codes as the
// RV64 architecture defines them
// --------------------------------------

`include "len5_params.svh"

package isa_pkg;

    // --------------------------------------
    // Data
    // --------------------------------------

    // One architectural register value
    typedef logic [`LEN5_XLEN-1:0] xlen_t;

    // --------------------------------------
    // Exceptions
    // --------------------------------------

    // Compact exception code carried on the CDB
    typedef logic [1:0] except_code_t;

    // Matches the RISC-V mcause value for this trap
    localparam except_code_t E_ILLEGAL_INSTRUCTION = 2'd2;

endpackage

//--- include/len5_params.svh
// --------------------------------------
// LEN5 execution unit parameters
// Global sizes shared by the ALU unit:
// data word, reservation station depth
// and reorder-buffer tag width
// --------------------------------------

`ifndef LEN5_PARAMS_SVH
`define LEN5_PARAMS_SVH

// --------------------------------------
// Datapath
// --------------------------------------

// RV64 data word
`define LEN5_XLEN 64

// --------------------------------------
// Reservation station and ROB
// --------------------------------------

// Entries in the ALU reservation station, power of two
`define LEN5_RS_DEPTH 4

// Reorder-buffer tag bits
`define LEN5_ROB_TAG_LEN 4

`endif
